// File: design/ddr_avalon_pkg.sv
/* Memory-side types for the Avalon-MM DDR port.
   Beat word, byte enables, beat address, burst length and request struct */
package ddr_avalon_pkg;

	// ------------------------------------------------------------
	// Geometry of the DDR window
	// ------------------------------------------------------------
	// 1 MB seen by the console GPU
	localparam int SPACE_BYTES = 1 << 20;
	localparam int WORD_BITS   = 64;
	// One enable per byte of a beat
	localparam int BE_BITS     = WORD_BITS / 8;
	// Address counts beats, not bytes
	localparam int ADDR_W      = $clog2(SPACE_BYTES / BE_BITS);
	// Avalon burstcount port width
	localparam int BURST_W     = 3;

	typedef logic [WORD_BITS-1:0] ddr_word_t;
	typedef logic [BE_BITS-1:0]   ddr_be_t;
	typedef logic [ADDR_W-1:0]    ddr_addr_t;
	typedef logic [BURST_W-1:0]   ddr_burst_t;

	// Request as it leaves the sequencer
	typedef struct packed {
		ddr_addr_t  address;
		ddr_burst_t burst_length;
		logic       write_enable;
		logic       read_enable;
		ddr_word_t  data;
		ddr_be_t    byte_enable;
	} ddr_req_s;

endpackage

// File: design/psx_mem_pkg.sv
/* Client-side types of the GPU memory port.
   Size encoding, address fields, pixel mask, block union and command struct */
package psx_mem_pkg;

	// ------------------------------------------------------------
	// Block geometry
	// ------------------------------------------------------------
	localparam int BLOCK_BYTES  = 32;
	localparam int PIXEL_BITS   = 16;
	// Beats and pixels follow from the block size
	localparam int BLOCK_BEATS  = BLOCK_BYTES / ddr_avalon_pkg::BE_BITS;
	localparam int BLOCK_PIXELS = BLOCK_BYTES * 8 / PIXEL_BITS;
	// 32768 blocks in 1 MB
	localparam int BLK_ADDR_W   = $clog2(ddr_avalon_pkg::SPACE_BYTES / BLOCK_BYTES);
	// Sub-address is in 4-byte units
	localparam int SUB_ADDR_W   = $clog2(BLOCK_BYTES / 4);

	typedef logic [BLK_ADDR_W-1:0]   blk_addr_t;
	typedef logic [SUB_ADDR_W-1:0]   sub_addr_t;
	typedef logic [BLOCK_PIXELS-1:0] pix_mask_t;
	typedef logic [PIXEL_BITS-1:0]   pixel_t;

	// Codes 2 and 3 are reserved, handled as 8 bytes
	typedef enum logic [1:0] {
		SIZE_8B  = 2'd0,
		SIZE_32B = 2'd1
	} cmd_size_e;

	// Same block word, seen as pixels or as DDR beats
	typedef union packed {
		pixel_t [BLOCK_PIXELS-1:0]                  pixels;
		ddr_avalon_pkg::ddr_word_t [BLOCK_BEATS-1:0] beats;
	} gpu_block_u;

	// One client command
	typedef struct packed {
		logic       write;
		cmd_size_e  size;
		blk_addr_t  blk_addr;
		sub_addr_t  sub_addr;
		pix_mask_t  mask;
		gpu_block_u data;
	} gpu_mem_cmd_s;

endpackage

// File: design/ddr_cmd_capture.sv
/* Command capture for the GPU to DDR bridge.
   Size decode, pixel mask to byte enable expansion, lane load strobe */
`timescale 1ns/1ps

module ddr_cmd_capture #(
	parameter int NUM_BEATS = 4
) (
	input  logic                                     clk,
	input  logic                                     i_rst_n,
	input  logic                                     i_cmd,
	input  psx_mem_pkg::gpu_mem_cmd_s                i_cmd_req,
	output logic                                     o_lane_load,
	output psx_mem_pkg::gpu_block_u                  o_lane_block,
	output ddr_avalon_pkg::ddr_be_t [NUM_BEATS-1:0]  o_lane_be,
	output logic                                     o_start,
	output logic                                     o_write,
	output psx_mem_pkg::blk_addr_t                   o_blk_addr,
	output logic [$clog2(NUM_BEATS)-1:0]             o_first_beat,
	output logic [$clog2(NUM_BEATS+1)-1:0]           o_beat_count
);

	import psx_mem_pkg::*;
	import ddr_avalon_pkg::*;

	localparam int BEAT_W = $clog2(NUM_BEATS);
	localparam int CNT_W  = $clog2(NUM_BEATS + 1);
	// Sub-address units per beat, as a shift
	localparam int SUB_SHIFT = $clog2(BE_BITS / 4);

	gpu_block_u pix_fill;
	logic       is_block;

	// ------------------------------------------------------------
	// Mask expansion
	// ------------------------------------------------------------
	// Every pixel bit copied over its 16 bits
	always_comb begin
		for (int p = 0; p < BLOCK_PIXELS; p++) begin
			pix_fill.pixels[p] = {PIXEL_BITS{i_cmd_req.mask[p]}};
		end
	end

	// Lowest bit of each byte of the filled word
	// gives that byte's enable, two bytes per pixel
	always_comb begin
		for (int b = 0; b < NUM_BEATS; b++) begin
			for (int j = 0; j < BE_BITS; j++) begin
				o_lane_be[b][j] = pix_fill.beats[b][8*j];
			end
		end
	end

	// Masked-out pixels travel as zero
	// memory drops them through the byte enables anyway
	assign o_lane_block.beats = i_cmd_req.data.beats & pix_fill.beats;

	// Lanes take the data on the command edge itself
	assign o_lane_load = i_cmd;

	// Reserved size codes fall back to a single beat
	assign is_block = (i_cmd_req.size == SIZE_32B);

	// ------------------------------------------------------------
	// Command register
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_start      <= 1'b0;
			o_write      <= 1'b0;
			o_blk_addr   <= '0;
			o_first_beat <= '0;
			o_beat_count <= '0;
		end else begin
			// One-cycle start toward the sequencer
			o_start <= i_cmd;
			if (i_cmd) begin
				o_write    <= i_cmd_req.write;
				o_blk_addr <= i_cmd_req.blk_addr;
				if (is_block) begin
					// Whole block from beat 0
					o_first_beat <= '0;
					o_beat_count <= CNT_W'(NUM_BEATS);
				end else begin
					// Single beat picked by sub_addr
					o_first_beat <= BEAT_W'(i_cmd_req.sub_addr >> SUB_SHIFT);
					o_beat_count <= CNT_W'(1);
				end
			end
		end
	end

endmodule

// File: design/ddr_beat_lane.sv
/* One beat slot of the bridge.
   Write word and enables for the burst, read beat holding register */
`timescale 1ns/1ps

module ddr_beat_lane #(
	parameter int LANE_IDX = 0
) (
	input  logic                                  clk,
	input  logic                                  i_rst_n,
	input  logic                                  i_load,
	input  ddr_avalon_pkg::ddr_word_t             i_wr_word,
	input  ddr_avalon_pkg::ddr_be_t               i_wr_be,
	input  logic                                  i_clear,
	input  logic [psx_mem_pkg::BLOCK_BEATS-1:0]   i_rd_capture,
	input  ddr_avalon_pkg::ddr_word_t             i_rd_word,
	output ddr_avalon_pkg::ddr_word_t             o_wr_word,
	output ddr_avalon_pkg::ddr_be_t               o_wr_be,
	output ddr_avalon_pkg::ddr_word_t             o_rd_word
);

	logic take_beat;

	// Strobe vector is one-hot on the beat counter
	assign take_beat = i_rd_capture[LANE_IDX];

	// ------------------------------------------------------------
	// Write side
	// ------------------------------------------------------------
	// Loaded once per command, read by the sequencer
	// while it walks the burst
	always_ff @(posedge clk) begin
		if (i_load) begin
			o_wr_word <= i_wr_word;
			o_wr_be   <= i_wr_be;
		end
	end

	// ------------------------------------------------------------
	// Read side
	// ------------------------------------------------------------
	// Zero at command start so unread beats come back as zero
	always_ff @(posedge clk) begin
		if (!i_rst_n || i_clear) begin
			o_rd_word <= '0;
		end else if (take_beat) begin
			// Returning beat for this slot
			o_rd_word <= i_rd_word;
		end
	end

endmodule

// File: design/ddr_burst_sequencer.sv
/* Avalon-MM burst FSM of the bridge.
   Write burst walk, read request, beat return routing, busy and data valid */
`timescale 1ns/1ps

module ddr_burst_sequencer #(
	parameter int NUM_BEATS = 4
) (
	input  logic                                      clk,
	input  logic                                      i_rst_n,
	input  logic                                      i_start,
	input  logic                                      i_write,
	input  psx_mem_pkg::blk_addr_t                    i_blk_addr,
	input  logic [$clog2(NUM_BEATS)-1:0]              i_first_beat,
	input  logic [$clog2(NUM_BEATS+1)-1:0]            i_beat_count,
	input  ddr_avalon_pkg::ddr_word_t [NUM_BEATS-1:0] i_lane_wr_word,
	input  ddr_avalon_pkg::ddr_be_t [NUM_BEATS-1:0]   i_lane_wr_be,
	input  logic                                      i_busy_mem,
	input  logic                                      i_data_valid_mem,
	input  ddr_avalon_pkg::ddr_word_t                 i_data_mem,
	output ddr_avalon_pkg::ddr_req_s                  o_req,
	output logic [NUM_BEATS-1:0]                      o_rd_capture,
	output ddr_avalon_pkg::ddr_word_t                 o_rd_word,
	output logic                                      o_lane_clear,
	output logic                                      o_busy,
	output logic                                      o_data_valid
);

	import psx_mem_pkg::*;
	import ddr_avalon_pkg::*;

	localparam int BEAT_W = $clog2(NUM_BEATS);
	localparam int CNT_W  = $clog2(NUM_BEATS + 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_WRITE,
		S_RD_REQ,
		S_RD_WAIT,
		S_DONE
	} state_e;

	state_e             state_q;
	logic               wr_q;
	blk_addr_t          blk_q;
	logic [BEAT_W-1:0]  first_q;
	logic [CNT_W-1:0]   count_q;
	// Current lane, and beats still to go
	logic [BEAT_W-1:0]  beat_q;
	logic [CNT_W-1:0]   left_q;
	logic               last_beat;
	logic               wr_phase;

	assign last_beat = (left_q == CNT_W'(1));
	assign wr_phase  = (state_q == S_WRITE);

	// ------------------------------------------------------------
	// State machine
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state_q <= S_IDLE;
			wr_q    <= 1'b0;
			blk_q   <= '0;
			first_q <= '0;
			count_q <= '0;
			beat_q  <= '0;
			left_q  <= '0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (i_start) begin
						wr_q    <= i_write;
						blk_q   <= i_blk_addr;
						first_q <= i_first_beat;
						count_q <= i_beat_count;
						beat_q  <= i_first_beat;
						left_q  <= i_beat_count;
						state_q <= i_write ? S_WRITE : S_RD_REQ;
					end
				end
				// One beat per cycle without wait-request
				S_WRITE: begin
					if (!i_busy_mem) begin
						if (last_beat) begin
							state_q <= S_DONE;
						end else begin
							beat_q <= beat_q + 1'b1;
							left_q <= left_q - 1'b1;
						end
					end
				end
				// Single request cycle carries the burst length
				S_RD_REQ: begin
					if (!i_busy_mem) begin
						state_q <= S_RD_WAIT;
					end
				end
				// Beats return in order
				S_RD_WAIT: begin
					if (i_data_valid_mem) begin
						if (last_beat) begin
							state_q <= S_DONE;
						end else begin
							beat_q <= beat_q + 1'b1;
							left_q <= left_q - 1'b1;
						end
					end
				end
				// Busy already low here, client may send next
				S_DONE: begin
					state_q <= S_IDLE;
				end
				default: begin
					state_q <= S_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// Avalon request
	// ------------------------------------------------------------
	// Burst address is the first beat, held for the whole burst
	always_comb begin
		o_req.address      = ddr_addr_t'({blk_q, first_q});
		o_req.burst_length = ddr_burst_t'(count_q);
		o_req.write_enable = wr_phase;
		o_req.read_enable  = (state_q == S_RD_REQ);
		o_req.data         = wr_phase ? i_lane_wr_word[beat_q] : '0;
		o_req.byte_enable  = wr_phase ? i_lane_wr_be[beat_q] : '0;
	end

	// Returning beat goes to the lane under the counter
	always_comb begin
		o_rd_capture = '0;
		if ((state_q == S_RD_WAIT) && i_data_valid_mem) begin
			o_rd_capture[beat_q] = 1'b1;
		end
	end

	assign o_rd_word = i_data_mem;

	// Old read words dropped when a command begins
	assign o_lane_clear = i_start && (state_q == S_IDLE);

	// Start counted in so busy is up the cycle after the command
	assign o_busy = i_start || (state_q inside {S_WRITE, S_RD_REQ, S_RD_WAIT});

	// Read done pulse, one cycle
	assign o_data_valid = (state_q == S_DONE) && !wr_q;

endmodule

// File: design/psx_ddr_bridge.sv
/* Top of the GPU block client to Avalon-MM DDR bridge.
   Command capture, beat lanes and burst sequencer */
`timescale 1ns/1ps

module psx_ddr_bridge #(
	parameter int NUM_BEATS = 4
) (
	input  logic                        clk,
	input  logic                        i_rst_n,
	input  logic                        i_cmd,
	input  psx_mem_pkg::gpu_mem_cmd_s   i_cmd_req,
	output logic                        o_busy,
	output logic                        o_data_valid,
	output psx_mem_pkg::gpu_block_u     o_rd_block,
	output ddr_avalon_pkg::ddr_addr_t   o_target_addr,
	output ddr_avalon_pkg::ddr_burst_t  o_burst_length,
	input  logic                        i_busy_mem,
	output logic                        o_write_enable_mem,
	output logic                        o_read_enable_mem,
	output ddr_avalon_pkg::ddr_word_t   o_data_mem,
	output ddr_avalon_pkg::ddr_be_t     o_byte_enable_mem,
	input  logic                        i_data_valid_mem,
	input  ddr_avalon_pkg::ddr_word_t   i_data_mem
);

	import psx_mem_pkg::*;
	import ddr_avalon_pkg::*;

	localparam int BEAT_W = $clog2(NUM_BEATS);
	localparam int CNT_W  = $clog2(NUM_BEATS + 1);

	// Capture to lanes and sequencer
	logic                         lane_load;
	gpu_block_u                   lane_block;
	ddr_be_t [NUM_BEATS-1:0]      lane_be;
	logic                         start;
	logic                         cmd_write;
	blk_addr_t                    blk_addr;
	logic [BEAT_W-1:0]            first_beat;
	logic [CNT_W-1:0]             beat_count;

	// Lanes to sequencer and client
	ddr_word_t [NUM_BEATS-1:0]    lane_wr_word;
	ddr_be_t [NUM_BEATS-1:0]      lane_wr_be;
	ddr_word_t [NUM_BEATS-1:0]    lane_rd_word;

	// Sequencer to lanes and Avalon port
	logic [NUM_BEATS-1:0]         rd_capture;
	ddr_word_t                    rd_word;
	logic                         lane_clear;
	ddr_req_s                     req;

	ddr_cmd_capture #(
		.NUM_BEATS (NUM_BEATS)
	) u_capture (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_cmd        (i_cmd),
		.i_cmd_req    (i_cmd_req),
		.o_lane_load  (lane_load),
		.o_lane_block (lane_block),
		.o_lane_be    (lane_be),
		.o_start      (start),
		.o_write      (cmd_write),
		.o_blk_addr   (blk_addr),
		.o_first_beat (first_beat),
		.o_beat_count (beat_count)
	);

	// ------------------------------------------------------------
	// Beat lanes, one per 64-bit beat of the block
	// ------------------------------------------------------------
	for (genvar i = 0; i < NUM_BEATS; i++) begin : g_lane
		ddr_beat_lane #(
			.LANE_IDX (i)
		) u_lane (
			.clk          (clk),
			.i_rst_n      (i_rst_n),
			.i_load       (lane_load),
			.i_wr_word    (lane_block.beats[i]),
			.i_wr_be      (lane_be[i]),
			.i_clear      (lane_clear),
			.i_rd_capture (rd_capture),
			.i_rd_word    (rd_word),
			.o_wr_word    (lane_wr_word[i]),
			.o_wr_be      (lane_wr_be[i]),
			.o_rd_word    (lane_rd_word[i])
		);
	end

	ddr_burst_sequencer #(
		.NUM_BEATS (NUM_BEATS)
	) u_sequencer (
		.clk              (clk),
		.i_rst_n          (i_rst_n),
		.i_start          (start),
		.i_write          (cmd_write),
		.i_blk_addr       (blk_addr),
		.i_first_beat     (first_beat),
		.i_beat_count     (beat_count),
		.i_lane_wr_word   (lane_wr_word),
		.i_lane_wr_be     (lane_wr_be),
		.i_busy_mem       (i_busy_mem),
		.i_data_valid_mem (i_data_valid_mem),
		.i_data_mem       (i_data_mem),
		.o_req            (req),
		.o_rd_capture     (rd_capture),
		.o_rd_word        (rd_word),
		.o_lane_clear     (lane_clear),
		.o_busy           (o_busy),
		.o_data_valid     (o_data_valid)
	);

	// Lane read words rebuild the block
	assign o_rd_block.beats = lane_rd_word;

	// Request struct onto the Avalon pins
	assign o_target_addr      = req.address;
	assign o_burst_length     = req.burst_length;
	assign o_write_enable_mem = req.write_enable;
	assign o_read_enable_mem  = req.read_enable;
	assign o_data_mem         = req.data;
	assign o_byte_enable_mem  = req.byte_enable;

endmodule

// File: sim/tb_clock_gen.sv
/* Testbench clock and reset source.
   8 ns clock, synchronous active-low reset held for 16 cycles */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_NS      = 4,
	parameter int RESET_CYCLES = 16
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever #HALF_NS o_clk = ~o_clk;
	end

	// Released on a rising edge, like any other driven input
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

endmodule

// File: sim/ddr_mem_model.sv
/* Avalon-MM DDR memory model for the bridge testbench.
   Random wait-request and read latency, byte-enable writes, sparse backing array */
`timescale 1ns/1ps

module ddr_mem_model (
	input  logic                        clk,
	input  logic                        i_rst_n,
	input  ddr_avalon_pkg::ddr_addr_t   i_address,
	input  ddr_avalon_pkg::ddr_burst_t  i_burst_length,
	input  logic                        i_write,
	input  logic                        i_read,
	input  ddr_avalon_pkg::ddr_word_t   i_writedata,
	input  ddr_avalon_pkg::ddr_be_t     i_byteenable,
	output logic                        o_waitrequest,
	output logic                        o_readdatavalid,
	output ddr_avalon_pkg::ddr_word_t   o_readdata
);

	import ddr_avalon_pkg::*;

	// Only written beats are stored
	ddr_word_t   mem [ddr_addr_t];
	// Beat addresses of the read burst still to return
	ddr_addr_t   rd_pending [$];
	ddr_burst_t  wr_beat;
	int unsigned gap;

	// Never-written beats, every address bit shows up in the word
	function automatic ddr_word_t fill_word(input ddr_addr_t a);
		return {15'h2AAA, a, 15'h5555, ~a};
	endfunction

	function automatic ddr_word_t peek(input ddr_addr_t a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return fill_word(a);
	endfunction

	initial begin
		o_waitrequest   = 1'b0;
		o_readdatavalid = 1'b0;
		o_readdata      = '0;
	end

	// ------------------------------------------------------------
	// Slave port
	// ------------------------------------------------------------
	always @(posedge clk) begin
		ddr_addr_t wa;
		ddr_word_t w;
		if (!i_rst_n) begin
			o_waitrequest   <= 1'b0;
			o_readdatavalid <= 1'b0;
			o_readdata      <= '0;
			wr_beat         <= '0;
			gap             <= 0;
			rd_pending.delete();
		end else begin
			// Roughly one stall cycle in four
			o_waitrequest   <= (($urandom % 4) == 0);
			o_readdatavalid <= 1'b0;
			// Burst address stays on the first beat, count locally
			if (i_write && !o_waitrequest) begin
				wa = i_address + ddr_addr_t'(wr_beat);
				w  = peek(wa);
				for (int j = 0; j < BE_BITS; j++) begin
					if (i_byteenable[j]) begin
						w[8*j +: 8] = i_writedata[8*j +: 8];
					end
				end
				mem[wa] = w;
				if (wr_beat + 3'd1 == i_burst_length) begin
					wr_beat <= '0;
				end else begin
					wr_beat <= wr_beat + 3'd1;
				end
			end
			if (i_read && !o_waitrequest) begin
				for (int i = 0; i < int'(i_burst_length); i++) begin
					rd_pending.push_back(i_address + ddr_addr_t'(i));
				end
				// Latency before the first beat
				gap <= $urandom % 4;
			end else if (rd_pending.size() != 0) begin
				if (gap == 0) begin
					o_readdatavalid <= 1'b1;
					o_readdata      <= peek(rd_pending.pop_front());
					// Gaps between beats too
					gap             <= $urandom % 3;
				end else begin
					gap <= gap - 1;
				end
			end
		end
	end

endmodule

// File: sim/psx_ddr_bridge_assertions.sv
/* Avalon protocol and client handshake assertions.
   Bound into the bridge top level */
`timescale 1ns/1ps

module psx_ddr_bridge_assertions (
	input logic                        clk,
	input logic                        i_rst_n,
	input logic                        i_busy_mem,
	input ddr_avalon_pkg::ddr_addr_t   o_target_addr,
	input ddr_avalon_pkg::ddr_burst_t  o_burst_length,
	input logic                        o_write_enable_mem,
	input logic                        o_read_enable_mem,
	input ddr_avalon_pkg::ddr_word_t   o_data_mem,
	input ddr_avalon_pkg::ddr_be_t     o_byte_enable_mem,
	input logic                        o_busy,
	input logic                        o_data_valid
);

	import ddr_avalon_pkg::*;

	// Failures seen so far, watched by the testbench
	int unsigned fail_count = 0;
	ddr_req_s    req_view;

	// Pins gathered back into one request
	assign req_view = {o_target_addr, o_burst_length, o_write_enable_mem,
		o_read_enable_mem, o_data_mem, o_byte_enable_mem};

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(o_write_enable_mem && o_read_enable_mem))
	else begin
		fail_count++;
		$error("write enable and read enable high in the same cycle");
	end

	// Stalled request must not move
	a_req_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
		((o_write_enable_mem || o_read_enable_mem) && i_busy_mem) |=> $stable(req_view))
	else begin
		fail_count++;
		$error("request changed while wait-request was high");
	end

	a_valid_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_data_valid |=> !o_data_valid)
	else begin
		fail_count++;
		$error("data valid high for two cycles in a row");
	end

	a_reset_quiet: assert property (@(posedge clk)
		!i_rst_n |=> (!o_busy && !o_data_valid && !o_write_enable_mem && !o_read_enable_mem))
	else begin
		fail_count++;
		$error("bridge outputs not low after reset");
	end

endmodule

// File: sim/tb_psx_ddr_bridge.sv
/* Testbench of the GPU to DDR bridge.
   Command table, shadow memory, completion wait with timeout, compare tasks */
`timescale 1ns/1ps

module tb_psx_ddr_bridge;

	import psx_mem_pkg::*;
	import ddr_avalon_pkg::*;

	localparam int          NUM_BEATS  = 4;
	localparam int          MAX_WAIT   = 400;
	localparam int          RESET_WAIT = 64;
	localparam logic [31:0] SEED       = 32'h0328_8240;

	// One table row with its data drawn at run time
	typedef struct {
		string     name;
		logic      write;
		cmd_size_e size;
		blk_addr_t blk;
		sub_addr_t sub;
		pix_mask_t mask;
	} step_s;

	logic         clk;
	logic         rst_n;
	logic         cmd;
	gpu_mem_cmd_s cmd_req;
	logic         busy;
	logic         data_valid;
	gpu_block_u   rd_block;
	ddr_addr_t    mem_addr;
	ddr_burst_t   mem_burst;
	logic         mem_busy;
	logic         mem_we;
	logic         mem_re;
	ddr_word_t    mem_wdata;
	ddr_be_t      mem_be;
	logic         mem_rvalid;
	ddr_word_t    mem_rdata;

	step_s        steps [$];
	// Expected DDR contents by beat address
	ddr_word_t    shadow_mem [ddr_addr_t];

	tb_clock_gen u_clk (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	psx_ddr_bridge #(
		.NUM_BEATS (NUM_BEATS)
	) u_dut (
		.clk                (clk),
		.i_rst_n            (rst_n),
		.i_cmd              (cmd),
		.i_cmd_req          (cmd_req),
		.o_busy             (busy),
		.o_data_valid       (data_valid),
		.o_rd_block         (rd_block),
		.o_target_addr      (mem_addr),
		.o_burst_length     (mem_burst),
		.i_busy_mem         (mem_busy),
		.o_write_enable_mem (mem_we),
		.o_read_enable_mem  (mem_re),
		.o_data_mem         (mem_wdata),
		.o_byte_enable_mem  (mem_be),
		.i_data_valid_mem   (mem_rvalid),
		.i_data_mem         (mem_rdata)
	);

	ddr_mem_model u_mem (
		.clk             (clk),
		.i_rst_n         (rst_n),
		.i_address       (mem_addr),
		.i_burst_length  (mem_burst),
		.i_write         (mem_we),
		.i_read          (mem_re),
		.i_writedata     (mem_wdata),
		.i_byteenable    (mem_be),
		.o_waitrequest   (mem_busy),
		.o_readdatavalid (mem_rvalid),
		.o_readdata      (mem_rdata)
	);

	bind psx_ddr_bridge psx_ddr_bridge_assertions u_assertions (
		.clk                (clk),
		.i_rst_n            (i_rst_n),
		.i_busy_mem         (i_busy_mem),
		.o_target_addr      (o_target_addr),
		.o_burst_length     (o_burst_length),
		.o_write_enable_mem (o_write_enable_mem),
		.o_read_enable_mem  (o_read_enable_mem),
		.o_data_mem         (o_data_mem),
		.o_byte_enable_mem  (o_byte_enable_mem),
		.o_busy             (o_busy),
		.o_data_valid       (o_data_valid)
	);

	// ------------------------------------------------------------
	// Failure reporting and compares
	// ------------------------------------------------------------
	task automatic stop_on_failure();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_block(input string name, input gpu_block_u exp, input gpu_block_u act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
			stop_on_failure();
		end
	endtask

	// ------------------------------------------------------------
	// Shadow memory
	// ------------------------------------------------------------
	// Never-written beats carry the model's address pattern
	function automatic ddr_word_t shadow_word(input ddr_addr_t a);
		if (shadow_mem.exists(a)) begin
			return shadow_mem[a];
		end
		return {15'h2AAA, a, 15'h5555, ~a};
	endfunction

	function automatic ddr_addr_t beat_addr(input blk_addr_t blk, input int b);
		return {blk, 2'(b)};
	endfunction

	// Byte 2k and 2k+1 of beat b follow mask bit 4b+k
	function automatic void shadow_write(input gpu_mem_cmd_s c, input int first, input int cnt);
		ddr_word_t w;
		ddr_addr_t a;
		for (int b = first; b < first + cnt; b++) begin
			a = beat_addr(c.blk_addr, b);
			w = shadow_word(a);
			for (int j = 0; j < 8; j++) begin
				if (c.mask[4*b + j/2]) begin
					w[8*j +: 8] = c.data.beats[b][8*j +: 8];
				end
			end
			shadow_mem[a] = w;
		end
	endfunction

	// Beats outside the access read back as zero
	function automatic gpu_block_u expected_read(input blk_addr_t blk, input int first,
		input int cnt);
		gpu_block_u exp;
		exp = '0;
		for (int b = first; b < first + cnt; b++) begin
			exp.beats[b] = shadow_word(beat_addr(blk, b));
		end
		return exp;
	endfunction

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------
	task automatic add_step(input string name, input logic wr, input cmd_size_e size,
		input blk_addr_t blk, input sub_addr_t sub, input pix_mask_t mask);
		step_s s;
		s.name  = name;
		s.write = wr;
		s.size  = size;
		s.blk   = blk;
		s.sub   = sub;
		s.mask  = mask;
		steps.push_back(s);
	endtask

	task automatic build_table();
		add_step("w32 full mask", 1'b1, SIZE_32B, 15'h0123, 3'd0, 16'hFFFF);
		add_step("r32 full mask", 1'b0, SIZE_32B, 15'h0123, 3'd0, 16'h0000);
		add_step("w32 partial mask", 1'b1, SIZE_32B, 15'h0123, 3'd0, 16'hA5C3);
		add_step("r32 partial mask", 1'b0, SIZE_32B, 15'h0123, 3'd0, 16'h0000);
		add_step("w8 beat 0", 1'b1, SIZE_8B, 15'h4ABC, 3'd0, 16'hFFFF);
		add_step("r8 beat 0", 1'b0, SIZE_8B, 15'h4ABC, 3'd0, 16'h0000);
		add_step("w8 beat 1", 1'b1, SIZE_8B, 15'h4ABC, 3'd3, 16'hFFFF);
		add_step("r8 beat 1", 1'b0, SIZE_8B, 15'h4ABC, 3'd2, 16'h0000);
		add_step("w8 beat 2", 1'b1, SIZE_8B, 15'h4ABC, 3'd4, 16'hFFFF);
		add_step("r8 beat 2", 1'b0, SIZE_8B, 15'h4ABC, 3'd5, 16'h0000);
		add_step("w8 beat 3", 1'b1, SIZE_8B, 15'h4ABC, 3'd7, 16'hFFFF);
		add_step("r8 beat 3", 1'b0, SIZE_8B, 15'h4ABC, 3'd6, 16'h0000);
		add_step("r32 after w8", 1'b0, SIZE_32B, 15'h4ABC, 3'd0, 16'h0000);
		// Two middle pixels of beat 2 only
		add_step("w8 partial beat 2", 1'b1, SIZE_8B, 15'h4ABC, 3'd5, 16'h0600);
		add_step("w reserved size", 1'b1, cmd_size_e'(2'd3), 15'h7FFF, 3'd2, 16'hFFFF);
		add_step("r32 reserved block", 1'b0, SIZE_32B, 15'h7FFF, 3'd0, 16'h0000);
		add_step("r reserved size", 1'b0, cmd_size_e'(2'd2), 15'h4ABC, 3'd5, 16'h0000);
		add_step("r32 fresh block", 1'b0, SIZE_32B, 15'h0000, 3'd0, 16'h0000);
		add_step("r32 final", 1'b0, SIZE_32B, 15'h4ABC, 3'd0, 16'h0000);
	endtask

	task automatic wait_reset();
		int cycles;
		cycles = 0;
		while (!rst_n) begin
			@(posedge clk);
			cycles++;
			if (cycles > RESET_WAIT) begin
				$display("ERROR: reset was never released");
				stop_on_failure();
			end
		end
		@(negedge clk);
	endtask

	// Issue one command, wait for busy low, check the result
	task automatic run_step(input step_s s);
		gpu_mem_cmd_s c;
		int           first;
		int           cnt;
		int           pulses;
		int           cycles;
		logic         finished;
		c          = '0;
		c.write    = s.write;
		c.size     = s.size;
		c.blk_addr = s.blk;
		c.sub_addr = s.sub;
		c.mask     = s.mask;
		for (int b = 0; b < NUM_BEATS; b++) begin
			c.data.beats[b] = {$urandom, $urandom};
		end
		// Reserved codes act as one beat
		first = (s.size == SIZE_32B) ? 0 : int'(s.sub[2:1]);
		cnt   = (s.size == SIZE_32B) ? NUM_BEATS : 1;
		@(posedge clk);
		cmd     <= 1'b1;
		cmd_req <= c;
		@(posedge clk);
		cmd     <= 1'b0;
		@(negedge clk);
		check_bit({s.name, " busy after command"}, 1'b1, busy);
		pulses   = 0;
		cycles   = 0;
		finished = 1'b0;
		while (!finished) begin
			if (data_valid) begin
				pulses++;
			end
			if (!busy) begin
				finished = 1'b1;
			end else begin
				cycles++;
				if (cycles > MAX_WAIT) begin
					$display("ERROR: bridge never finished the command %s", s.name);
					stop_on_failure();
				end
				@(negedge clk);
			end
		end
		check_bit({s.name, " data valid seen"}, !s.write, pulses > 0);
		check_bit({s.name, " single data valid"}, 1'b1, pulses <= 1);
		if (s.write) begin
			shadow_write(c, first, cnt);
		end else begin
			check_block({s.name, " read block"}, expected_read(s.blk, first, cnt), rd_block);
		end
	endtask

	// Bound assertions end the run at once
	always @(negedge clk) begin
		if (u_dut.u_assertions.fail_count != 0) begin
			$display("ERROR: a protocol assertion on the bridge fired");
			stop_on_failure();
		end
	end

	initial begin
		cmd     = 1'b0;
		cmd_req = '0;
		void'($urandom(SEED));
		build_table();
		wait_reset();
		check_bit("busy after reset", 1'b0, busy);
		check_bit("data valid after reset", 1'b0, data_valid);
		foreach (steps[i]) begin
			run_step(steps[i]);
		end
		@(negedge clk);
		if (u_dut.u_assertions.fail_count != 0) begin
			$display("ERROR: a protocol assertion on the bridge fired");
			stop_on_failure();
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

// File: build.f
design/ddr_avalon_pkg.sv
design/psx_mem_pkg.sv
design/ddr_cmd_capture.sv
design/ddr_beat_lane.sv
design/ddr_burst_sequencer.sv
design/psx_ddr_bridge.sv
sim/tb_clock_gen.sv
sim/ddr_mem_model.sv
sim/psx_ddr_bridge_assertions.sv
sim/tb_psx_ddr_bridge.sv

// File: Bender.yml
package:
  name: psx_ddr_bridge

sources:
  - files:
      - design/ddr_avalon_pkg.sv
      - design/psx_mem_pkg.sv
      - design/ddr_cmd_capture.sv
      - design/ddr_beat_lane.sv
      - design/ddr_burst_sequencer.sv
      - design/psx_ddr_bridge.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/ddr_mem_model.sv
      - sim/psx_ddr_bridge_assertions.sv
      - sim/tb_psx_ddr_bridge.sv
